// ==== design/rv32i_pkg.sv ====
// RV32I shared word types, opcode, ALU, branch and select enums, funct3 codes, halt word
`default_nettype none

package rv32i_pkg;

  localparam int unsigned WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [4:0]        reg_idx_t;

  // Major opcodes handled by this core
  typedef enum logic [6:0] {
    REGREG = 7'b0110011,
    IMMED  = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  // Same values as the branch funct3 field
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef enum logic {
    A_RS1 = 1'b0,
    A_PC  = 1'b1
  } a_sel_t;

  typedef enum logic {
    B_RS2 = 1'b0,
    B_IMM = 1'b1
  } b_sel_t;

  typedef enum logic [1:0] {
    W_ALU   = 2'd0,
    W_PC4   = 2'd1,
    W_IMM_U = 2'd2
  } w_sel_t;

  // Register-register funct3 codes
  localparam logic [2:0] ADDSUB = 3'b000;
  localparam logic [2:0] SLL    = 3'b001;
  localparam logic [2:0] SLT    = 3'b010;
  localparam logic [2:0] SLTU   = 3'b011;
  localparam logic [2:0] XOR    = 3'b100;
  localparam logic [2:0] SR     = 3'b101;
  localparam logic [2:0] OR     = 3'b110;
  localparam logic [2:0] AND    = 3'b111;

  // Register-immediate funct3 codes
  localparam logic [2:0] ADDI  = 3'b000;
  localparam logic [2:0] SLLI  = 3'b001;
  localparam logic [2:0] SLTI  = 3'b010;
  localparam logic [2:0] SLTIU = 3'b011;
  localparam logic [2:0] XORI  = 3'b100;
  localparam logic [2:0] SRI   = 3'b101;
  localparam logic [2:0] ORI   = 3'b110;
  localparam logic [2:0] ANDI  = 3'b111;

  // jal x0, 0 spins forever, so it serves as the stop word
  localparam word_t HALT_WORD = 32'h0000_006f;

endpackage

`default_nettype wire

// ==== design/control_unit.sv ====
// Combinational RV32I decoder for immediates, operand and writeback selects, ALU op and flags
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  rv32i_pkg::word_t    instr_i,
  output rv32i_pkg::reg_idx_t rs1_idx_o,
  output rv32i_pkg::reg_idx_t rs2_idx_o,
  output rv32i_pkg::reg_idx_t rd_idx_o,
  output rv32i_pkg::word_t    imm_o,
  output rv32i_pkg::word_t    imm_u_o,
  output rv32i_pkg::a_sel_t   a_sel_o,
  output rv32i_pkg::b_sel_t   b_sel_o,
  output rv32i_pkg::w_sel_t   w_sel_o,
  output rv32i_pkg::alu_op_t  alu_op_o,
  output rv32i_pkg::branch_t  branch_type_o,
  output logic                branch_o,
  output logic                jal_o,
  output logic                jalr_o,
  output logic                wen_o,
  output logic                illegal_o,
  output logic                halt_o
);
  import rv32i_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i_fmt;
  word_t      imm_b_fmt;
  word_t      imm_j_fmt;

  logic is_immed;
  logic is_regreg;
  logic is_sr;
  logic is_addsub;
  logic aluop_sll;
  logic aluop_sra;
  logic aluop_srl;
  logic aluop_add;
  logic aluop_sub;
  logic aluop_and;
  logic aluop_or;
  logic aluop_xor;
  logic aluop_slt;
  logic aluop_sltu;

  assign opcode = opcode_t'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign rs1_idx_o = instr_i[19:15];
  assign rs2_idx_o = instr_i[24:20];
  assign rd_idx_o  = instr_i[11:7];

  // Immediate formats, all sign extended from bit 31
  assign imm_i_fmt = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_b_fmt = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                      instr_i[11:8], 1'b0};
  assign imm_j_fmt = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                      instr_i[30:21], 1'b0};
  assign imm_u_o   = {instr_i[31:12], 12'b0};

  always_comb begin
    case (opcode)
      BRANCH     : imm_o = imm_b_fmt;
      JAL        : imm_o = imm_j_fmt;
      LUI, AUIPC : imm_o = imm_u_o;
      default    : imm_o = imm_i_fmt;
    endcase
  end

  assign branch_type_o = branch_t'(funct3);
  assign branch_o      = (opcode == BRANCH);
  assign jal_o         = (opcode == JAL);
  assign jalr_o        = (opcode == JALR);

  assign a_sel_o = (opcode == AUIPC) ? A_PC : A_RS1;
  assign b_sel_o = (opcode == REGREG) ? B_RS2 : B_IMM;

  always_comb begin
    case (opcode)
      JAL, JALR : w_sel_o = W_PC4;
      LUI       : w_sel_o = W_IMM_U;
      default   : w_sel_o = W_ALU;
    endcase
  end

  always_comb begin
    case (opcode)
      REGREG, IMMED, LUI, AUIPC, JAL, JALR : wen_o = 1'b1;
      default                              : wen_o = 1'b0;
    endcase
  end

  // ALU op flags
  assign is_immed  = (opcode == IMMED);
  assign is_regreg = (opcode == REGREG);
  assign is_sr     = (is_immed && funct3 == SRI) || (is_regreg && funct3 == SR);
  assign is_addsub = is_regreg && funct3 == ADDSUB;

  assign aluop_sll  = (is_immed && funct3 == SLLI) || (is_regreg && funct3 == SLL);
  assign aluop_sra  = is_sr && instr_i[30];
  assign aluop_srl  = is_sr && !instr_i[30];
  assign aluop_add  = (is_immed && funct3 == ADDI) || (opcode == AUIPC) ||
                      (is_addsub && !instr_i[30]);
  assign aluop_sub  = is_addsub && instr_i[30];
  assign aluop_and  = (is_immed && funct3 == ANDI) || (is_regreg && funct3 == AND);
  assign aluop_or   = (is_immed && funct3 == ORI) || (is_regreg && funct3 == OR);
  assign aluop_xor  = (is_immed && funct3 == XORI) || (is_regreg && funct3 == XOR);
  assign aluop_slt  = (is_immed && funct3 == SLTI) || (is_regreg && funct3 == SLT);
  assign aluop_sltu = (is_immed && funct3 == SLTIU) || (is_regreg && funct3 == SLTU);

  // Priority chain, falls back to add for JALR target and unused cases
  always_comb begin
    if (aluop_sll)
      alu_op_o = ALU_SLL;
    else if (aluop_sra)
      alu_op_o = ALU_SRA;
    else if (aluop_srl)
      alu_op_o = ALU_SRL;
    else if (aluop_add)
      alu_op_o = ALU_ADD;
    else if (aluop_sub)
      alu_op_o = ALU_SUB;
    else if (aluop_and)
      alu_op_o = ALU_AND;
    else if (aluop_or)
      alu_op_o = ALU_OR;
    else if (aluop_xor)
      alu_op_o = ALU_XOR;
    else if (aluop_slt)
      alu_op_o = ALU_SLT;
    else if (aluop_sltu)
      alu_op_o = ALU_SLTU;
    else
      alu_op_o = ALU_ADD;
  end

  // Only bit 30 of funct7 may be set on a register-register op
  always_comb begin
    case (opcode)
      REGREG                              : illegal_o = |(funct7 & 7'b101_1111);
      IMMED, LUI, AUIPC, JAL, JALR, BRANCH : illegal_o = 1'b0;
      default                             : illegal_o = 1'b1;
    endcase
  end

  assign halt_o = (instr_i == HALT_WORD);

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
// RV32I integer register file with x0 tied to zero, two read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                wen_i,
  input  rv32i_pkg::reg_idx_t rd_idx_i,
  input  rv32i_pkg::reg_idx_t rs1_idx_i,
  input  rv32i_pkg::reg_idx_t rs2_idx_i,
  input  rv32i_pkg::word_t    wdata_i,
  output rv32i_pkg::word_t    rs1_data_o,
  output rv32i_pkg::word_t    rs2_data_o
);
  import rv32i_pkg::*;

  // No storage behind x0
  word_t regs [1:31];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_idx_i != '0) begin
      regs[rd_idx_i] <= wdata_i;
    end
  end

  assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule

`default_nettype wire

// ==== design/execute_unit.sv ====
// ALU operand muxes, ten-operation RV32I ALU and writeback value mux
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  rv32i_pkg::word_t   pc_i,
  input  rv32i_pkg::word_t   rs1_data_i,
  input  rv32i_pkg::word_t   rs2_data_i,
  input  rv32i_pkg::word_t   imm_i,
  input  rv32i_pkg::word_t   imm_u_i,
  input  rv32i_pkg::a_sel_t  a_sel_i,
  input  rv32i_pkg::b_sel_t  b_sel_i,
  input  rv32i_pkg::w_sel_t  w_sel_i,
  input  rv32i_pkg::alu_op_t alu_op_i,
  output rv32i_pkg::word_t   alu_result_o,
  output rv32i_pkg::word_t   wb_data_o
);
  import rv32i_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;

  assign op_a  = (a_sel_i == A_PC) ? pc_i : rs1_data_i;
  assign op_b  = (b_sel_i == B_IMM) ? imm_i : rs2_data_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op_i)
      ALU_SUB  : alu_result_o = op_a - op_b;
      ALU_SLL  : alu_result_o = op_a << shamt;
      ALU_SLT  : alu_result_o = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU : alu_result_o = {31'b0, op_a < op_b};
      ALU_XOR  : alu_result_o = op_a ^ op_b;
      ALU_SRL  : alu_result_o = op_a >> shamt;
      ALU_SRA  : alu_result_o = $signed(op_a) >>> shamt;
      ALU_OR   : alu_result_o = op_a | op_b;
      ALU_AND  : alu_result_o = op_a & op_b;
      default  : alu_result_o = op_a + op_b;
    endcase
  end

  // Link address for jumps, U immediate for LUI
  always_comb begin
    case (w_sel_i)
      W_PC4   : wb_data_o = pc_i + 32'd4;
      W_IMM_U : wb_data_o = imm_u_i;
      default : wb_data_o = alu_result_o;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/pc_unit.sv ====
// Program counter register with branch compare and next-PC selection
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
  parameter rv32i_pkg::word_t RESET_PC = '0
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               advance_i,
  input  logic               branch_i,
  input  logic               jal_i,
  input  logic               jalr_i,
  input  rv32i_pkg::branch_t branch_type_i,
  input  rv32i_pkg::word_t   rs1_data_i,
  input  rv32i_pkg::word_t   rs2_data_i,
  input  rv32i_pkg::word_t   imm_i,
  input  rv32i_pkg::word_t   alu_result_i,
  output rv32i_pkg::word_t   pc_o
);
  import rv32i_pkg::*;

  word_t pc_q;
  word_t pc_next;
  logic  taken;
  logic  eq;
  logic  lt;
  logic  ltu;

  assign eq  = (rs1_data_i == rs2_data_i);
  assign lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
  assign ltu = (rs1_data_i < rs2_data_i);

  always_comb begin
    case (branch_type_i)
      BEQ     : taken = eq;
      BNE     : taken = !eq;
      BLT     : taken = lt;
      BGE     : taken = !lt;
      BLTU    : taken = ltu;
      BGEU    : taken = !ltu;
      default : taken = 1'b0;
    endcase
  end

  always_comb begin
    if (jalr_i)
      pc_next = {alu_result_i[31:1], 1'b0};
    else if (jal_i || (branch_i && taken))
      pc_next = pc_q + imm_i;
    else
      pc_next = pc_q + 32'd4;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q <= RESET_PC;
    end else if (advance_i) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== design/rv32i_exec_core.sv ====
// RV32I execution core top with halt flag and registered writeback and trap outputs
`timescale 1ns/1ps
`default_nettype none

module rv32i_exec_core #(
  parameter rv32i_pkg::word_t RESET_PC = '0
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                instr_valid_i,
  input  rv32i_pkg::word_t    instr_i,
  output logic                wb_valid_o,
  output logic                trap_o,
  output logic                halted_o,
  output rv32i_pkg::reg_idx_t wb_rd_o,
  output rv32i_pkg::word_t    wb_data_o,
  output rv32i_pkg::word_t    pc_o
);
  import rv32i_pkg::*;

  reg_idx_t rs1_idx, rs2_idx, rd_idx;
  word_t    imm, imm_u;
  a_sel_t   a_sel;
  b_sel_t   b_sel;
  w_sel_t   w_sel;
  alu_op_t  alu_op;
  branch_t  branch_type;
  logic     branch, jal, jalr, wen, illegal, halt;
  word_t    rs1_data, rs2_data, alu_result, wb_data, pc;

  logic halted_q;
  logic issue;
  logic rf_wen;

  // Strobes are dropped once halted
  assign issue  = instr_valid_i && !halted_q;
  assign rf_wen = issue && wen && !illegal;

  control_unit u_control_unit (
    .instr_i       (instr_i),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .rd_idx_o      (rd_idx),
    .imm_o         (imm),
    .imm_u_o       (imm_u),
    .a_sel_o       (a_sel),
    .b_sel_o       (b_sel),
    .w_sel_o       (w_sel),
    .alu_op_o      (alu_op),
    .branch_type_o (branch_type),
    .branch_o      (branch),
    .jal_o         (jal),
    .jalr_o        (jalr),
    .wen_o         (wen),
    .illegal_o     (illegal),
    .halt_o        (halt)
  );

  reg_file u_reg_file (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wen_i      (rf_wen),
    .rd_idx_i   (rd_idx),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .wdata_i    (wb_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  execute_unit u_execute_unit (
    .pc_i         (pc),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .imm_i        (imm),
    .imm_u_i      (imm_u),
    .a_sel_i      (a_sel),
    .b_sel_i      (b_sel),
    .w_sel_i      (w_sel),
    .alu_op_i     (alu_op),
    .alu_result_o (alu_result),
    .wb_data_o    (wb_data)
  );

  pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_pc_unit (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .advance_i     (issue),
    .branch_i      (branch),
    .jal_i         (jal),
    .jalr_i        (jalr),
    .branch_type_i (branch_type),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .imm_i         (imm),
    .alu_result_i  (alu_result),
    .pc_o          (pc)
  );

  // Status pulses and sticky halt
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      halted_q   <= 1'b0;
      wb_valid_o <= 1'b0;
      trap_o     <= 1'b0;
    end else begin
      halted_q   <= halted_q || (issue && halt);
      wb_valid_o <= rf_wen && (rd_idx != '0);
      trap_o     <= issue && illegal;
    end
  end

  // Writeback payload, only meaningful with wb_valid_o
  always_ff @(posedge clk_i) begin
    if (issue) begin
      wb_rd_o   <= rd_idx;
      wb_data_o <= wb_data;
    end
  end

  assign halted_o = halted_q;
  assign pc_o     = pc;

endmodule

`default_nettype wire

// ==== verification/rv32i_exec_core_checker.sv ====
// Bound assertions on the core status outputs: reset state, pulse exclusivity, sticky halt
`timescale 1ns/1ps
`default_nettype none

module rv32i_exec_core_checker (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                wb_valid_o,
  input logic                trap_o,
  input logic                halted_o,
  input rv32i_pkg::reg_idx_t wb_rd_o
);

  // Read by the testbench at the end of the run
  int unsigned assert_failures = 0;

  // First cycle out of reset shows the cleared status flags
  a_reset_status : assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !wb_valid_o && !trap_o && !halted_o)
    else begin
      $error("status outputs not low after reset");
      assert_failures++;
    end

  a_wb_trap_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wb_valid_o && trap_o))
    else begin
      $error("wb_valid_o and trap_o high together");
      assert_failures++;
    end

  a_wb_rd_nonzero : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_o |-> wb_rd_o != '0)
    else begin
      $error("wb_valid_o with wb_rd_o equal to zero");
      assert_failures++;
    end

  // Only a reset seen at the previous edge may clear halted_o
  a_halt_sticky : assert property (@(posedge clk_i)
    $past(rst_n_i) |-> !$fell(halted_o))
    else begin
      $error("halted_o fell without reset");
      assert_failures++;
    end

endmodule

`default_nettype wire

// ==== verification/rv32i_exec_core_tb.sv ====
// Clock, reset, random instruction stream, reference model and compare process for the core
`timescale 1ns/1ps
`default_nettype none

module rv32i_exec_core_tb;
  import rv32i_pkg::*;

  localparam word_t       RESET_PC       = 32'h0000_0100;
  localparam word_t       HALT_INSTR     = 32'h0000_006f;
  localparam int unsigned NUM_INSTR      = 400;
  localparam int unsigned NUM_AFTER_HALT = 8;
  localparam int unsigned STIM_CYCLES    = 4 + NUM_INSTR + 1 + NUM_AFTER_HALT + 4;
  localparam int unsigned TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  typedef struct packed {
    logic     wb_valid;
    reg_idx_t rd;
    word_t    data;
    logic     trap;
    word_t    pc;
    logic     halted;
  } exp_t;

  logic     clk_i;
  logic     rst_n_i;
  logic     instr_valid_i;
  word_t    instr_i;
  logic     wb_valid_o;
  logic     trap_o;
  logic     halted_o;
  reg_idx_t wb_rd_o;
  word_t    wb_data_o;
  word_t    pc_o;

  word_t       lcg_state;
  word_t       model_regs [0:31];
  word_t       model_pc;
  logic        model_halted;
  exp_t        exp_q [$];
  exp_t        pending;
  logic        have_pending;
  int unsigned errors;
  int unsigned checks;
  int unsigned cycles;

  rv32i_exec_core #(
    .RESET_PC (RESET_PC)
  ) uut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .trap_o        (trap_o),
    .halted_o      (halted_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .pc_o          (pc_o)
  );

  bind rv32i_exec_core rv32i_exec_core_checker u_checker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wb_valid_o (wb_valid_o),
    .trap_o     (trap_o),
    .halted_o   (halted_o),
    .wb_rd_o    (wb_rd_o)
  );

  always #2 clk_i = ~clk_i;

  function automatic word_t next_rand();
    word_t hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi = lcg_state;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi[31:16], lcg_state[31:16]};
  endfunction

  // Random fields over the supported opcodes with about one word in eight illegal
  function automatic word_t make_instr();
    word_t r;
    word_t w;
    r = next_rand();
    w = next_rand();
    // Half the indices come from x0..x7 for dependencies and x0 hits
    w[11:7]  = r[3] ? {2'b00, r[6:4]} : r[8:4];
    w[19:15] = r[9] ? {2'b00, r[12:10]} : r[14:10];
    w[24:20] = r[15] ? {2'b00, r[18:16]} : r[20:16];
    w[14:12] = r[23:21];
    case (r[2:0])
      3'd0: begin
        w[6:0]   = 7'h33;
        w[31:25] = {1'b0, r[24], 5'b0};
      end
      3'd1: begin
        w[6:0] = 7'h13;
        if (w[14:12] == 3'b001)
          w[31:25] = 7'h00;
        else if (w[14:12] == 3'b101)
          w[31:25] = {1'b0, r[24], 5'b0};
      end
      3'd2: w[6:0] = r[25] ? 7'h37 : 7'h17;
      3'd3: w[6:0] = 7'h6f;
      3'd4: begin
        w[6:0]   = 7'h67;
        w[14:12] = 3'b000;
      end
      3'd5, 3'd6: begin
        w[6:0] = 7'h63;
        // funct3 2 and 3 are no branch and become 6 and 7
        if (w[14:13] == 2'b01)
          w[14] = 1'b1;
      end
      default: begin
        case (r[27:26])
          2'd0: w[6:0] = 7'h03;
          2'd1: w[6:0] = 7'h73;
          2'd2: w[6:0] = 7'h23;
          default: begin
            w[6:0] = 7'h33;
            w[25]  = 1'b1;
          end
        endcase
      end
    endcase
    if (w == HALT_INSTR)
      w[7] = 1'b1;
    return w;
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    word_t res;
    case (f3)
      3'b000: res = alt ? a - b : a + b;
      3'b001: res = a << b[4:0];
      3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: res = (a < b) ? 32'd1 : 32'd0;
      3'b100: res = a ^ b;
      3'b101: begin
        if (alt)
          res = $signed(a) >>> b[4:0];
        else
          res = a >> b[4:0];
      end
      3'b110: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  // Reference model that advances the model state by one cycle
  function automatic exp_t predict(input word_t instr, input logic valid);
    exp_t       e;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      res;
    word_t      next_pc;
    logic       writes;
    logic       illegal;
    logic       taken;
    e        = '0;
    e.pc     = model_pc;
    e.halted = model_halted;
    if (!valid || model_halted)
      return e;
    f3      = instr[14:12];
    a       = model_regs[instr[19:15]];
    b       = model_regs[instr[24:20]];
    imm_i   = {{20{instr[31]}}, instr[31:20]};
    imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u   = {instr[31:12], 12'h000};
    imm_j   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    next_pc = model_pc + 32'd4;
    res     = '0;
    writes  = 1'b0;
    illegal = 1'b0;
    case (instr[6:0])
      7'h33: begin
        if ((instr[31:25] & 7'h5f) != 7'h00) begin
          illegal = 1'b1;
        end else begin
          writes = 1'b1;
          res    = alu_ref(f3, instr[30], a, b);
        end
      end
      7'h13: begin
        writes = 1'b1;
        res    = alu_ref(f3, (f3 == 3'b101) && instr[30], a, imm_i);
      end
      7'h37: begin
        writes = 1'b1;
        res    = imm_u;
      end
      7'h17: begin
        writes = 1'b1;
        res    = model_pc + imm_u;
      end
      7'h6f: begin
        writes  = 1'b1;
        res     = model_pc + 32'd4;
        next_pc = model_pc + imm_j;
        if (instr == HALT_INSTR)
          model_halted = 1'b1;
      end
      7'h67: begin
        writes  = 1'b1;
        res     = model_pc + 32'd4;
        next_pc = (a + imm_i) & 32'hffff_fffe;
      end
      7'h63: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          3'b111:  taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (taken)
          next_pc = model_pc + imm_b;
      end
      default: illegal = 1'b1;
    endcase
    if (writes && instr[11:7] != 5'd0) begin
      model_regs[instr[11:7]] = res;
      e.wb_valid = 1'b1;
      e.rd       = instr[11:7];
      e.data     = res;
    end
    model_pc = next_pc;
    e.trap   = illegal;
    e.pc     = next_pc;
    e.halted = model_halted;
    return e;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Expectation is queued at the edge where it takes effect
  task automatic drive_cycle(input logic valid, input word_t word);
    @(posedge clk_i);
    if (have_pending)
      exp_q.push_back(pending);
    #1;
    instr_valid_i = valid;
    instr_i       = word;
    pending       = predict(word, valid);
    have_pending  = 1'b1;
  endtask

  always @(negedge clk_i) begin
    exp_t e;
    if (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      check_bit("wb_valid_o", wb_valid_o, e.wb_valid);
      if (e.wb_valid) begin
        check_idx("wb_rd_o", wb_rd_o, e.rd);
        check_word("wb_data_o", wb_data_o, e.data);
      end
      check_bit("trap_o", trap_o, e.trap);
      check_word("pc_o", pc_o, e.pc);
      check_bit("halted_o", halted_o, e.halted);
      checks++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    lcg_state     = 32'd7759;
    model_pc      = RESET_PC;
    model_halted  = 1'b0;
    have_pending  = 1'b0;
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    @(negedge clk_i);
    check_word("pc_o", pc_o, RESET_PC);

    // Random stream with idle cycles carrying garbage words
    for (int i = 0; i < NUM_INSTR; i++) begin
      if (next_rand() % 8 == 0)
        drive_cycle(1'b0, next_rand());
      else
        drive_cycle(1'b1, make_instr());
    end

    // Halt followed by strobes that must be ignored
    drive_cycle(1'b1, HALT_INSTR);
    for (int i = 0; i < NUM_AFTER_HALT; i++) begin
      drive_cycle(1'b1, make_instr());
    end

    @(posedge clk_i);
    exp_q.push_back(pending);
    #1 instr_valid_i = 1'b0;
    repeat (2) @(negedge clk_i);

    $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
             checks, errors, uut.u_checker.assert_failures);
    if (errors == 0 && uut.u_checker.assert_failures == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv32i_exec_core.f ====
design/rv32i_pkg.sv
design/control_unit.sv
design/reg_file.sv
design/execute_unit.sv
design/pc_unit.sv
design/rv32i_exec_core.sv
verification/rv32i_exec_core_checker.sv
verification/rv32i_exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_exec_core

sources:
  - files:
      - design/rv32i_pkg.sv
      - design/control_unit.sv
      - design/reg_file.sv
      - design/execute_unit.sv
      - design/pc_unit.sv
      - design/rv32i_exec_core.sv
  - target: test
    files:
      - verification/rv32i_exec_core_checker.sv
      - verification/rv32i_exec_core_tb.sv
